// File: z80_pkg.sv
`default_nettype none

package z80_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;
	localparam int R_W = 7; // refresh counter

	typedef enum logic [2:0]
	{
		MC_FETCH,
		MC_MEM_RD,
		MC_MEM_WR,
		MC_IO_RD,
		MC_IO_WR
	} m_cycle_e;

	typedef enum logic [2:0]
	{
		T1,
		T2,
		TW, // io only
		T3,
		T4  // fetch only
	} t_state_e;

	typedef enum logic [7:0]
	{
		OP_NOP      = 8'h00,
		OP_LD_A_N   = 8'h3e,
		OP_JP_NN    = 8'hc3,
		OP_LD_A_MEM = 8'h3a,
		OP_LD_MEM_A = 8'h32,
		OP_OUT_N_A  = 8'hd3,
		OP_IN_A_N   = 8'hdb,
		OP_HALT     = 8'h76
	} opcode_e;

	typedef enum logic [2:0]
	{
		CL_NOP,
		CL_LD_IMM,
		CL_JP,
		CL_LD_MEM,
		CL_ST_MEM,
		CL_OUT,
		CL_IN,
		CL_HALT
	} op_class_e;

endpackage

`default_nettype wire

// File: bus_cycle_if.sv
`timescale 1ns/100ps
`default_nettype none

interface bus_cycle_if ();
	import z80_pkg::*;

	m_cycle_e cycle;
	t_state_e tstate;
	logic sample;     // wait check passed, data valid
	logic cycle_done; // last T-state of the machine cycle
	logic [1:0] step; // machine cycle index in the instruction

	modport seq
		(
		output cycle,
		output step,
		input cycle_done
		);

	modport timer
		(
		input cycle,
		output tstate,
		output sample,
		output cycle_done
		);

	modport bus
		(
		input cycle,
		input tstate,
		input sample
		);

	modport dp
		(
		input cycle,
		input tstate,
		input sample,
		input cycle_done,
		input step
		);

endinterface

`default_nettype wire

// File: opcode_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module opcode_decoder
	#(
	parameter int DATA_W = z80_pkg::DATA_W
	)
	(
	input wire MCLK,
	input wire arst_n_i,
	input wire [DATA_W-1:0] data_i,
	bus_cycle_if.dp cyc,
	output z80_pkg::op_class_e op_class_o
	);

	import z80_pkg::*;

	logic [DATA_W-1:0] ir;
	opcode_e op;

	always_ff @(posedge MCLK or negedge arst_n_i)
	begin
		if (!arst_n_i)
			ir <= '0; // nop
		else if (cyc.sample && (cyc.cycle == MC_FETCH))
			ir <= data_i;
	end

	assign op = opcode_e'(ir);

	always_comb
	begin
		case (op)
			OP_NOP:
				op_class_o = CL_NOP;
			OP_LD_A_N:
				op_class_o = CL_LD_IMM;
			OP_JP_NN:
				op_class_o = CL_JP;
			OP_LD_A_MEM:
				op_class_o = CL_LD_MEM;
			OP_LD_MEM_A:
				op_class_o = CL_ST_MEM;
			OP_OUT_N_A:
				op_class_o = CL_OUT;
			OP_IN_A_N:
				op_class_o = CL_IN;
			OP_HALT:
				op_class_o = CL_HALT;
			default:
				op_class_o = CL_NOP; // unsupported opcodes run as nop
		endcase
	end

endmodule

`default_nettype wire

// File: mcycle_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module mcycle_fsm
	(
	input wire MCLK,
	input wire arst_n_i,
	input var z80_pkg::op_class_e op_class_i,
	bus_cycle_if.seq cyc,
	output logic halt_n_o
	);

	import z80_pkg::*;

	m_cycle_e cycle_q, cycle_d;
	logic [1:0] step_q, step_d;
	logic halted;

	assign cyc.cycle = cycle_q;
	assign cyc.step = step_q;

	always_comb
	begin
		cycle_d = MC_FETCH;
		step_d = 2'd0;
		if (!halted)
		begin
			case (step_q)
				2'd0:
				begin
					if ((op_class_i != CL_NOP) && (op_class_i != CL_HALT))
					begin
						cycle_d = MC_MEM_RD; // first operand byte
						step_d = 2'd1;
					end
				end
				2'd1:
				begin
					step_d = 2'd2;
					case (op_class_i)
						CL_JP, CL_LD_MEM, CL_ST_MEM:
							cycle_d = MC_MEM_RD; // high byte of nn
						CL_OUT:
							cycle_d = MC_IO_WR;
						CL_IN:
							cycle_d = MC_IO_RD;
						default:
							step_d = 2'd0; // ld a,n ends here
					endcase
				end
				2'd2:
				begin
					step_d = 2'd3;
					case (op_class_i)
						CL_LD_MEM:
							cycle_d = MC_MEM_RD;
						CL_ST_MEM:
							cycle_d = MC_MEM_WR;
						default:
							step_d = 2'd0;
					endcase
				end
				default:
					step_d = 2'd0;
			endcase
		end
	end

	always_ff @(posedge MCLK or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			cycle_q <= MC_FETCH;
			step_q <= 2'd0;
			halted <= 1'b0;
			halt_n_o <= 1'b1;
		end
		else
		begin
			if (cyc.cycle_done)
			begin
				cycle_q <= cycle_d;
				step_q <= step_d;
				if ((step_q == 2'd0) && (op_class_i == CL_HALT))
					halted <= 1'b1; // only reset leaves halt
			end
			halt_n_o <= !halted; // lines up with the bus view
		end
	end

	a_halt_after_fetch: assert property (@(posedge MCLK) disable iff (!arst_n_i)
		$fell(halt_n_o) |-> $past(cyc.cycle_done, 2) && ($past(cycle_q, 2) == MC_FETCH))
		else $error("halt_n_o fell outside the end of a fetch");

endmodule

`default_nettype wire

// File: tstate_counter.sv
`timescale 1ns/100ps
`default_nettype none

module tstate_counter
	(
	input wire MCLK,
	input wire arst_n_i,
	input wire wait_n_i,
	bus_cycle_if.timer cyc
	);

	import z80_pkg::*;

	t_state_e tstate_q, tstate_d;
	logic is_io;
	logic passed;

	assign is_io = (cyc.cycle == MC_IO_RD) || (cyc.cycle == MC_IO_WR);
	// bus shows T2 or TW while this counter sits in T3
	assign passed = (tstate_q == T3) && wait_n_i;

	always_comb
	begin
		case (tstate_q)
			T1:
				tstate_d = T2;
			T2:
				tstate_d = is_io ? TW : T3; // automatic io wait
			TW:
				tstate_d = T3;
			T3:
				if (!wait_n_i)
					tstate_d = T3;
				else if (cyc.cycle == MC_FETCH)
					tstate_d = T4;
				else
					tstate_d = T1;
			default:
				tstate_d = T1;
		endcase
	end

	always_ff @(posedge MCLK or negedge arst_n_i)
	begin
		if (!arst_n_i)
			tstate_q <= T1;
		else
			tstate_q <= tstate_d;
	end

	assign cyc.tstate = tstate_q;
	assign cyc.sample = passed;
	assign cyc.cycle_done = (tstate_q == T4) || (passed && (cyc.cycle != MC_FETCH));

	a_tw_io_only: assert property (@(posedge MCLK) disable iff (!arst_n_i)
		(tstate_q == TW) |-> is_io ##1 (tstate_q == T3))
		else $error("TW outside an io cycle");

	a_t4_fetch_only: assert property (@(posedge MCLK) disable iff (!arst_n_i)
		(tstate_q == T4) |-> (cyc.cycle == MC_FETCH) ##1 (tstate_q == T1))
		else $error("T4 outside a fetch cycle");

endmodule

`default_nettype wire

// File: bus_strobes.sv
`timescale 1ns/100ps
`default_nettype none

module bus_strobes
	(
	input wire MCLK,
	input wire arst_n_i,
	bus_cycle_if.bus cyc,
	output logic mreq_n_o,
	output logic iorq_n_o,
	output logic rd_n_o,
	output logic wr_n_o,
	output logic m1_n_o,
	output logic rfsh_n_o
	);

	import z80_pkg::*;

	logic hold;
	logic early; // T1 or T2
	logic io_act; // T2 or TW
	logic mreq_d, iorq_d, rd_d, wr_d, m1_d, rfsh_d;

	assign hold = (cyc.tstate == T3) && !cyc.sample; // wait stretch
	assign early = (cyc.tstate == T1) || (cyc.tstate == T2);
	assign io_act = (cyc.tstate == T2) || (cyc.tstate == TW);

	always_comb
	begin
		mreq_d = 1'b1;
		iorq_d = 1'b1;
		rd_d = 1'b1;
		wr_d = 1'b1;
		m1_d = 1'b1;
		rfsh_d = 1'b1;
		case (cyc.cycle)
			MC_FETCH:
			begin
				m1_d = !early;
				rd_d = !early;
				mreq_d = (cyc.tstate == T4); // low in T1..T3
				rfsh_d = early;
			end
			MC_MEM_RD:
			begin
				mreq_d = !early;
				rd_d = !early;
			end
			MC_MEM_WR:
			begin
				mreq_d = !early;
				wr_d = !early;
			end
			MC_IO_RD:
			begin
				iorq_d = !io_act;
				rd_d = !io_act;
			end
			default:
			begin
				iorq_d = !io_act;
				wr_d = !io_act;
			end
		endcase
	end

	always_ff @(posedge MCLK or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			mreq_n_o <= 1'b1;
			iorq_n_o <= 1'b1;
			rd_n_o <= 1'b1;
			wr_n_o <= 1'b1;
			m1_n_o <= 1'b1;
			rfsh_n_o <= 1'b1;
		end
		else if (!hold)
		begin
			mreq_n_o <= mreq_d;
			iorq_n_o <= iorq_d;
			rd_n_o <= rd_d;
			wr_n_o <= wr_d;
			m1_n_o <= m1_d;
			rfsh_n_o <= rfsh_d;
		end
	end

	a_mreq_iorq: assert property (@(posedge MCLK) disable iff (!arst_n_i)
		!(!mreq_n_o && !iorq_n_o))
		else $error("mreq_n_o and iorq_n_o low together");

	a_rd_wr: assert property (@(posedge MCLK) disable iff (!arst_n_i)
		!(!rd_n_o && !wr_n_o))
		else $error("rd_n_o and wr_n_o low together");

endmodule

`default_nettype wire

// File: addr_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module addr_datapath
	#(
	parameter int ADDR_W = z80_pkg::ADDR_W,
	parameter int DATA_W = z80_pkg::DATA_W
	)
	(
	input wire MCLK,
	input wire arst_n_i,
	input wire [DATA_W-1:0] data_i,
	input var z80_pkg::op_class_e op_class_i,
	input wire halt_n_i,
	bus_cycle_if.dp cyc,
	output logic [ADDR_W-1:0] addr_o,
	output logic [DATA_W-1:0] data_o,
	output logic data_oe_o
	);

	import z80_pkg::*;

	logic [ADDR_W-1:0] pc;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] z; // operand low
	logic [DATA_W-1:0] w; // operand high
	logic [R_W-1:0] r;
	logic [ADDR_W-1:0] addr_d;
	logic hold;
	logic is_wr;

	assign hold = (cyc.tstate == T3) && !cyc.sample;
	assign is_wr = (cyc.cycle == MC_MEM_WR) || (cyc.cycle == MC_IO_WR);

	always_ff @(posedge MCLK or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			pc <= '0;
			a <= '0;
			r <= '0;
		end
		else
		begin
			if (cyc.sample)
			begin
				case (cyc.cycle)
					MC_FETCH:
						if (halt_n_i)
							pc <= pc + 1'b1; // frozen in halt
					MC_MEM_RD:
					begin
						if ((cyc.step == 2'd1) && (op_class_i == CL_LD_IMM))
							a <= data_i;
						if (cyc.step == 2'd3)
							a <= data_i; // ld a,(nn)
						else if ((cyc.step == 2'd2) && (op_class_i == CL_JP))
							pc <= {data_i, z};
						else
							pc <= pc + 1'b1;
					end
					MC_IO_RD:
						a <= data_i;
					default:
						;
				endcase
			end
			if (cyc.cycle_done && (cyc.cycle == MC_FETCH))
				r <= r + 1'b1; // 7 bits wrap
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (cyc.sample && (cyc.cycle == MC_MEM_RD) && (cyc.step == 2'd1))
			z <= data_i;
		if (cyc.sample && (cyc.cycle == MC_MEM_RD) && (cyc.step == 2'd2))
			w <= data_i;
		if (!hold && is_wr)
			data_o <= a;
	end

	always_comb
	begin
		case (cyc.cycle)
			MC_FETCH:
				if ((cyc.tstate == T3) || (cyc.tstate == T4))
					addr_d = {{(ADDR_W - R_W){1'b0}}, r}; // refresh
				else
					addr_d = pc;
			MC_MEM_RD:
				addr_d = (cyc.step == 2'd3) ? {w, z} : pc;
			MC_MEM_WR:
				addr_d = {w, z};
			default:
				addr_d = {a, z}; // io port
		endcase
	end

	always_ff @(posedge MCLK or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			addr_o <= '0;
			data_oe_o <= 1'b0;
		end
		else if (!hold)
		begin
			addr_o <= addr_d;
			data_oe_o <= is_wr;
		end
	end

	a_pc_frozen: assert property (@(posedge MCLK) disable iff (!arst_n_i)
		(!halt_n_i && $past(!halt_n_i)) |-> $stable(pc))
		else $error("pc moved while halted");

endmodule

`default_nettype wire

// File: z80_bus_top.sv
`timescale 1ns/100ps
`default_nettype none

module z80_bus_top
	#(
	parameter int ADDR_W = z80_pkg::ADDR_W,
	parameter int DATA_W = z80_pkg::DATA_W
	)
	(
	input wire MCLK,
	input wire arst_n_i,
	input wire [DATA_W-1:0] data_i,
	input wire wait_n_i,
	output wire [ADDR_W-1:0] addr_o,
	output wire [DATA_W-1:0] data_o,
	output wire data_oe_o,
	output wire mreq_n_o,
	output wire iorq_n_o,
	output wire rd_n_o,
	output wire wr_n_o,
	output wire m1_n_o,
	output wire rfsh_n_o,
	output wire halt_n_o
	);

	import z80_pkg::*;

	op_class_e op_class;

	bus_cycle_if cyc_if ();

	opcode_decoder #(.DATA_W(DATA_W)) u_decoder
		(
		.MCLK(MCLK),
		.arst_n_i(arst_n_i),
		.data_i(data_i),
		.cyc(cyc_if),
		.op_class_o(op_class)
		);

	mcycle_fsm u_mcycle
		(
		.MCLK(MCLK),
		.arst_n_i(arst_n_i),
		.op_class_i(op_class),
		.cyc(cyc_if),
		.halt_n_o(halt_n_o)
		);

	tstate_counter u_tstate
		(
		.MCLK(MCLK),
		.arst_n_i(arst_n_i),
		.wait_n_i(wait_n_i),
		.cyc(cyc_if)
		);

	bus_strobes u_strobes
		(
		.MCLK(MCLK),
		.arst_n_i(arst_n_i),
		.cyc(cyc_if),
		.mreq_n_o(mreq_n_o),
		.iorq_n_o(iorq_n_o),
		.rd_n_o(rd_n_o),
		.wr_n_o(wr_n_o),
		.m1_n_o(m1_n_o),
		.rfsh_n_o(rfsh_n_o)
		);

	addr_datapath #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_datapath
		(
		.MCLK(MCLK),
		.arst_n_i(arst_n_i),
		.data_i(data_i),
		.op_class_i(op_class),
		.halt_n_i(halt_n_o),
		.cyc(cyc_if),
		.addr_o(addr_o),
		.data_o(data_o),
		.data_oe_o(data_oe_o)
		);

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
	#(
	parameter int PERIOD = 10,
	parameter int RST_CYCLES = 4
	)
	(
	output logic clk_o,
	output logic arst_n_o
	);

	initial
	begin
		clk_o = 1'b0;
		forever
			#(PERIOD / 2) clk_o = !clk_o;
	end

	initial
	begin
		arst_n_o = 1'b0;
		repeat (RST_CYCLES)
			@(posedge clk_o);
		@(negedge clk_o);
		arst_n_o = 1'b1; // released on a falling edge
	end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model
	(
	input wire MCLK,
	input wire arst_n_i,
	input wire [15:0] addr_i,
	input wire [7:0] wdata_i,
	input wire mreq_n_i,
	input wire iorq_n_i,
	input wire rd_n_i,
	input wire wr_n_i,
	output logic [7:0] rdata_o,
	output logic wait_n_o
	);

	logic [7:0] mem [0:65535];
	logic [7:0] io [0:255];
	integer seed;
	integer wait_left;
	logic req_q;
	wire req;

	assign req = (!rd_n_i || !wr_n_i) && (!mreq_n_i || !iorq_n_i);

	initial
	begin
		seed = 32'hdd20;
		wait_left = 0;
		req_q = 1'b0;
		rdata_o = 8'h00;
		wait_n_o = 1'b1;
	end

	always @(negedge MCLK)
	begin
		if (!arst_n_i)
		begin
			wait_n_o <= 1'b1;
			rdata_o <= 8'h00;
			wait_left = 0;
			req_q = 1'b0;
		end
		else
		begin
			if (req && !req_q)
			begin
				wait_left = $random(seed) & 3; // 0..3 waits for this cycle
				wait_n_o <= 1'b1;
			end
			else if (req && (wait_left > 0))
			begin
				wait_n_o <= 1'b0;
				wait_left = wait_left - 1;
			end
			else
				wait_n_o <= 1'b1;
			if (!rd_n_i)
				rdata_o <= !iorq_n_i ? io[addr_i[7:0]] : mem[addr_i];
			if (!wr_n_i && !mreq_n_i)
				mem[addr_i] = wdata_i;
			if (!wr_n_i && !iorq_n_i)
				io[addr_i[7:0]] = wdata_i; // port from low byte
			req_q = req;
		end
	end

endmodule

`default_nettype wire

// File: tb_z80_bus.sv
`timescale 1ns/100ps
`default_nettype none

module tb_z80_bus;

	localparam logic [2:0] K_FETCH = 3'd0;
	localparam logic [2:0] K_MEM_RD = 3'd1;
	localparam logic [2:0] K_MEM_WR = 3'd2;
	localparam logic [2:0] K_IO_RD = 3'd3;
	localparam logic [2:0] K_IO_WR = 3'd4;
	localparam int HALT_FETCHES = 120; // takes R past its wrap

	typedef struct packed
	{
		logic [2:0] kind;
		logic [15:0] addr;
		logic [7:0] data;
		logic halted;
	} bus_txn_t;

	wire MCLK;
	wire arst_n;
	wire [7:0] rdata;
	wire wait_n;
	wire [15:0] addr;
	wire [7:0] wdata;
	wire data_oe, mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n, halt_n;
	wire strb_low;

	bus_txn_t exp_q[$];
	bus_txn_t cur;
	logic [7:0] ref_mem [0:65535];
	logic [7:0] ref_io [0:255];
	logic [2:0] obs_kind;
	logic txn_start;
	logic prev_act;
	logic [6:0] cur_r;
	int fetch_cnt, low_cnt, assert_errs, other_errs, cycles, limit, rfsh_seen;

	assign strb_low = !rd_n || !wr_n;

	tb_clock_gen #(.PERIOD(10), .RST_CYCLES(4)) u_clk (.clk_o(MCLK), .arst_n_o(arst_n));

	tb_mem_model u_mem
		(
		.MCLK(MCLK), .arst_n_i(arst_n), .addr_i(addr), .wdata_i(wdata),
		.mreq_n_i(mreq_n), .iorq_n_i(iorq_n), .rd_n_i(rd_n), .wr_n_i(wr_n),
		.rdata_o(rdata), .wait_n_o(wait_n)
		);

	z80_bus_top uut
		(
		.MCLK(MCLK), .arst_n_i(arst_n), .data_i(rdata), .wait_n_i(wait_n),
		.addr_o(addr), .data_o(wdata), .data_oe_o(data_oe),
		.mreq_n_o(mreq_n), .iorq_n_o(iorq_n), .rd_n_o(rd_n), .wr_n_o(wr_n),
		.m1_n_o(m1_n), .rfsh_n_o(rfsh_n), .halt_n_o(halt_n)
		);

	function automatic logic [7:0] fill_byte(input logic [15:0] a);
		return a[7:0] ^ a[15:8] ^ 8'ha5;
	endfunction

	function automatic logic [2:0] classify(input logic m1, input logic mreq, input logic wr);
		if (!m1)
			return K_FETCH;
		if (!mreq)
			return wr ? K_MEM_RD : K_MEM_WR;
		return wr ? K_IO_RD : K_IO_WR;
	endfunction

	task automatic put_byte(input logic [15:0] a, input logic [7:0] d);
		u_mem.mem[a] = d;
		ref_mem[a] = d;
	endtask

	task automatic expect_txn(input logic [2:0] k, input logic [15:0] a, input logic [7:0] d,
		input logic h);
		bus_txn_t t;
		t.kind = k;
		t.addr = a;
		t.data = d;
		t.halted = h;
		exp_q.push_back(t);
	endtask

	task automatic load_program;
		logic [7:0] prog [0:23];
		prog = '{8'h3e, 8'h5a, 8'h32, 8'h00, 8'h80, 8'h3e, 8'h00, 8'h3a,
			8'h00, 8'h80, 8'hd3, 8'h10, 8'h3e, 8'h33, 8'hdb, 8'h20,
			8'h32, 8'h01, 8'h80, 8'h00, 8'h0f, 8'hc3, 8'h00, 8'h90};
		for (int i = 0; i < 24; i++)
			put_byte(i[15:0], prog[i]);
		put_byte(16'h9000, 8'h76); // jump target halts
	endtask

	// walks the program by the cycle sequence rules
	task automatic build_expected;
		logic [15:0] pc;
		logic [7:0] a, op, lo, hi;
		logic halted;
		pc = '0;
		a = '0;
		halted = 1'b0;
		while (!halted)
		begin
			op = ref_mem[pc];
			expect_txn(K_FETCH, pc, op, 1'b0);
			pc++;
			case (op)
				8'h3e:
				begin
					a = ref_mem[pc];
					expect_txn(K_MEM_RD, pc, a, 1'b0);
					pc++;
				end
				8'hc3, 8'h3a, 8'h32:
				begin
					lo = ref_mem[pc];
					expect_txn(K_MEM_RD, pc, lo, 1'b0);
					pc++;
					hi = ref_mem[pc];
					expect_txn(K_MEM_RD, pc, hi, 1'b0);
					pc++;
					if (op == 8'hc3)
						pc = {hi, lo};
					else if (op == 8'h3a)
					begin
						a = ref_mem[{hi, lo}];
						expect_txn(K_MEM_RD, {hi, lo}, a, 1'b0);
					end
					else
					begin
						ref_mem[{hi, lo}] = a;
						expect_txn(K_MEM_WR, {hi, lo}, a, 1'b0);
					end
				end
				8'hd3:
				begin
					lo = ref_mem[pc];
					expect_txn(K_MEM_RD, pc, lo, 1'b0);
					pc++;
					ref_io[lo] = a;
					expect_txn(K_IO_WR, {a, lo}, a, 1'b0);
				end
				8'hdb:
				begin
					lo = ref_mem[pc];
					expect_txn(K_MEM_RD, pc, lo, 1'b0);
					pc++;
					expect_txn(K_IO_RD, {a, lo}, ref_io[lo], 1'b0);
					a = ref_io[lo];
				end
				8'h76:
					halted = 1'b1;
				default:
					;
			endcase
		end
		repeat (HALT_FETCHES)
			expect_txn(K_FETCH, pc, ref_mem[pc], 1'b1); // pc stays put
	endtask

	always @(negedge MCLK)
	begin
		logic act;
		act = (!rd_n || !wr_n) && (!mreq_n || !iorq_n);
		txn_start = 1'b0;
		low_cnt = strb_low ? low_cnt + 1 : 0;
		if (arst_n && act && !prev_act)
		begin
			if (exp_q.size() == 0)
			begin
				other_errs++;
				$display("unexpected bus cycle at %0t after the end of the program", $time);
			end
			else
			begin
				cur = exp_q.pop_front();
				obs_kind = classify(m1_n, mreq_n, wr_n);
				txn_start = 1'b1;
				if (cur.kind == K_FETCH)
				begin
					cur_r = fetch_cnt[6:0]; // one refresh step per fetch
					fetch_cnt++;
				end
			end
		end
		prev_act = act;
	end

	a_reset_idle: assert property (@(negedge MCLK)
		!arst_n |-> ({mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n, halt_n, !data_oe} == 8'hff))
		else
		begin
			assert_errs++;
			$display("[FAIL] %0t {mreq_n_o,iorq_n_o,rd_n_o,wr_n_o,m1_n_o,rfsh_n_o,%s} %s %h got %h",
				$time, "halt_n_o,!data_oe_o", "expected", 8'hff,
				$sampled({mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n, halt_n, !data_oe}));
		end

	a_kind: assert property (@(posedge MCLK) disable iff (!arst_n)
		txn_start |-> (obs_kind == cur.kind))
		else
		begin
			assert_errs++;
			$display("[FAIL] %0t m1_n_o/mreq_n_o/wr_n_o cycle kind expected %0d got %0d", $time,
				cur.kind, obs_kind);
		end

	a_addr: assert property (@(posedge MCLK) disable iff (!arst_n)
		txn_start |-> (addr == cur.addr))
		else
		begin
			assert_errs++;
			$display("[FAIL] %0t addr_o expected %h got %h", $time, cur.addr, $sampled(addr));
		end

	a_oe: assert property (@(posedge MCLK) disable iff (!arst_n)
		txn_start |-> (data_oe == ((cur.kind == K_MEM_WR) || (cur.kind == K_IO_WR))))
		else
		begin
			assert_errs++;
			$display("[FAIL] %0t data_oe_o expected %b got %b", $time,
				(cur.kind == K_MEM_WR) || (cur.kind == K_IO_WR), $sampled(data_oe));
		end

	a_wdata: assert property (@(posedge MCLK) disable iff (!arst_n)
		(txn_start && ((cur.kind == K_MEM_WR) || (cur.kind == K_IO_WR))) |-> (wdata == cur.data))
		else
		begin
			assert_errs++;
			$display("[FAIL] %0t data_o expected %h got %h", $time, cur.data, $sampled(wdata));
		end

	a_rfsh_addr: assert property (@(posedge MCLK) disable iff (!arst_n)
		!rfsh_n |-> (addr == {9'b0, cur_r}))
		else
		begin
			assert_errs++;
			$display("[FAIL] %0t refresh addr_o expected %h got %h", $time, {9'b0, cur_r},
				$sampled(addr));
		end

	// refresh covers T3 and T4 of every fetch
	a_fetch_rfsh: assert property (@(posedge MCLK) disable iff (!arst_n)
		$rose(m1_n) |-> !rfsh_n ##1 !rfsh_n ##1 rfsh_n)
		else
		begin
			assert_errs++;
			$display("[FAIL] %0t rfsh_n_o expected low in T3 and T4 only got %b", $time,
				$sampled(rfsh_n));
		end

	a_halt: assert property (@(posedge MCLK) disable iff (!arst_n)
		!rfsh_n |-> (halt_n == !cur.halted))
		else
		begin
			assert_errs++;
			$display("[FAIL] %0t halt_n_o expected %b got %b", $time, !cur.halted,
				$sampled(halt_n));
		end

	a_mreq_iorq: assert property (@(posedge MCLK) disable iff (!arst_n)
		!(!mreq_n && !iorq_n))
		else
		begin
			assert_errs++;
			$display("[FAIL] %0t iorq_n_o expected 1 got 0 while mreq_n_o low", $time);
		end

	// strobe width is two T-states plus every wait seen at its end
	a_min_width: assert property (@(posedge MCLK) disable iff (!arst_n)
		(strb_low && (low_cnt < 2)) |=> strb_low)
		else
		begin
			assert_errs++;
			$display("[FAIL] %0t rd_n_o/wr_n_o expected 0 got 1 before nominal end", $time);
		end

	a_wait_hold: assert property (@(posedge MCLK) disable iff (!arst_n)
		(strb_low && (low_cnt >= 2) && !wait_n) |=> strb_low)
		else
		begin
			assert_errs++;
			$display("[FAIL] %0t rd_n_o/wr_n_o expected 0 got 1 during wait", $time);
		end

	a_release: assert property (@(posedge MCLK) disable iff (!arst_n)
		(strb_low && (low_cnt >= 2) && wait_n) |=> !strb_low)
		else
		begin
			assert_errs++;
			$display("[FAIL] %0t rd_n_o/wr_n_o expected 1 got 0 after wait", $time);
		end

	initial
	begin
		assert_errs = 0;
		other_errs = 0;
		fetch_cnt = 0;
		low_cnt = 0;
		prev_act = 1'b0;
		txn_start = 1'b0;
		cur = '0;
		cur_r = '0;
		obs_kind = '0;
		cycles = 0;
		rfsh_seen = 0;
		for (int i = 0; i < 65536; i++)
		begin
			u_mem.mem[i] = fill_byte(i[15:0]);
			ref_mem[i] = fill_byte(i[15:0]);
		end
		for (int i = 0; i < 256; i++)
		begin
			u_mem.io[i] = i[7:0] ^ 8'h3c;
			ref_io[i] = i[7:0] ^ 8'h3c;
		end
		load_program();
		build_expected();
		limit = exp_q.size() * 4 * 4 + 50;
		wait (arst_n === 1'b1);
		// last fetch is done once its refresh has been seen twice
		while ((rfsh_seen < 2) && (cycles < limit))
		begin
			@(negedge MCLK);
			cycles++;
			if ((exp_q.size() == 0) && !rfsh_n)
				rfsh_seen++;
		end
		if (rfsh_seen < 2)
		begin
			other_errs++;
			$display("timeout: program did not finish within %0d cycles", limit);
		end
		if (halt_n !== 1'b0)
		begin
			other_errs++;
			$display("[FAIL] %0t halt_n_o expected 0 got %b", $time, halt_n);
		end
		$display("summary: %0d assertion failures, %0d other errors", assert_errs, other_errs);
		if ((assert_errs + other_errs) == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
z80_pkg.sv
bus_cycle_if.sv
opcode_decoder.sv
mcycle_fsm.sv
tstate_counter.sv
bus_strobes.sv
addr_datapath.sv
z80_bus_top.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_z80_bus.sv

// File: Bender.yml
package:
  name: z80_bus

sources:
  - z80_pkg.sv
  - bus_cycle_if.sv
  - opcode_decoder.sv
  - mcycle_fsm.sv
  - tstate_counter.sv
  - bus_strobes.sv
  - addr_datapath.sv
  - z80_bus_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_mem_model.sv
      - tb_z80_bus.sv
